/* logic/lc3Pkg.sv */
package lc3Pkg;

    ////////////////////
    // Base types
    ////////////////////
    localparam int wordWidth = 16;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [2:0] regIdx_t;
    typedef logic [2:0] cc_t;                   // n, z, p

    localparam cc_t ccResetVal = 3'b010;        // Zero flag set

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [3:0] {
        opBr   = 4'h0, opAdd = 4'h1, opLd   = 4'h2, opSt  = 4'h3,
        opJsr  = 4'h4, opAnd = 4'h5, opLdr  = 4'h6, opStr = 4'h7,
        opRti  = 4'h8, opNot = 4'h9, opLdi  = 4'hA, opSti = 4'hB,
        opJmp  = 4'hC, opRes = 4'hD, opLea  = 4'hE, opTrap = 4'hF
    } opcode_e;

    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPassA} aluOp_e;
    typedef enum logic [1:0] {busAlu, busAddr, busMdr, busPc} busSel_e;
    typedef enum logic [1:0] {pcInc, pcAddr, pcBus} pcSel_e;
    typedef enum logic [1:0] {addr2Zero, addr2Off6, addr2Off9} addr2Sel_e;
    typedef enum logic [1:0] {memNone, memRead, memWrite} memCmd_e;

    ////////////////////
    // Instruction formats
    ////////////////////
    typedef struct packed {
        opcode_e    opcode;
        regIdx_t    dr;
        regIdx_t    sr1;
        logic       immFlag;
        logic [4:0] imm5;                       // sr2 lives in the low three bits
    } operate_t;

    typedef struct packed {
        opcode_e    opcode;
        regIdx_t    dr;                         // Source register for ST
        logic [8:0] pcOffset9;
    } pcRel_t;

    typedef struct packed {
        opcode_e    opcode;
        regIdx_t    dr;
        regIdx_t    baseR;
        logic [5:0] offset6;
    } baseRel_t;

    typedef struct packed {
        opcode_e    opcode;
        logic       n;
        logic       z;
        logic       p;
        logic [8:0] pcOffset9;
    } branch_t;

    typedef union packed {
        operate_t operate;
        pcRel_t   pcRel;
        baseRel_t baseRel;
        branch_t  branch;
        word_t    raw;
    } instr_u;

    ////////////////////
    // Control and memory
    ////////////////////
    typedef struct packed {
        logic      ldReg;
        logic      ldIr;
        logic      ldPc;
        logic      ldCc;
        pcSel_e    pcSel;
        busSel_e   busSel;
        logic      addr1Base;                   // Base register instead of PC
        addr2Sel_e addr2Sel;
        aluOp_e    aluOp;
        regIdx_t   sr1;
        regIdx_t   sr2;
        regIdx_t   dr;
        logic      useImm;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } memReq_t;

endpackage

/* logic/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic            clk,
    input  logic            rst_n,
    input  lc3Pkg::regIdx_t sr1,
    input  lc3Pkg::regIdx_t sr2,
    input  lc3Pkg::regIdx_t dr,
    input  logic            ldReg,
    input  lc3Pkg::word_t   writeData,
    output lc3Pkg::word_t   rd1,
    output lc3Pkg::word_t   rd2
);

    lc3Pkg::word_t regs [8];        // R0 to R7

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ldReg) begin
            regs[dr] <= writeData;
        end
    end

    assign rd1 = regs[sr1];         // Read ports are combinational
    assign rd2 = regs[sr2];

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/10ps

module executeUnit (
    input  lc3Pkg::instr_u ir,
    input  lc3Pkg::ctrl_t  ctrl,
    input  lc3Pkg::word_t  rd1,
    input  lc3Pkg::word_t  rd2,
    input  lc3Pkg::word_t  pc,
    output lc3Pkg::word_t  aluOut,
    output lc3Pkg::word_t  addrSum
);

    lc3Pkg::word_t aluB;
    lc3Pkg::word_t addr1;
    lc3Pkg::word_t addr2;

    ////////////////////
    // ALU
    ////////////////////
    assign aluB = ctrl.useImm ? {{11{ir.operate.imm5[4]}}, ir.operate.imm5} : rd2;

    always_comb begin
        case (ctrl.aluOp)
            lc3Pkg::aluAdd: aluOut = rd1 + aluB;
            lc3Pkg::aluAnd: aluOut = rd1 & aluB;
            lc3Pkg::aluNot: aluOut = ~rd1;
            default:        aluOut = rd1;       // Pass SR1 through
        endcase
    end

    ////////////////////
    // Address adder
    ////////////////////
    assign addr1 = ctrl.addr1Base ? rd1 : pc;   // pc already points past this instruction

    always_comb begin
        case (ctrl.addr2Sel)
            lc3Pkg::addr2Off6: addr2 = {{10{ir.baseRel.offset6[5]}}, ir.baseRel.offset6};
            lc3Pkg::addr2Off9: addr2 = {{7{ir.pcRel.pcOffset9[8]}}, ir.pcRel.pcOffset9};
            default:           addr2 = '0;
        endcase
    end

    assign addrSum = addr1 + addr2;

endmodule

/* logic/dataPath.sv */
`timescale 1ns/10ps

module dataPath #(
    parameter lc3Pkg::word_t resetPc = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  lc3Pkg::ctrl_t  ctrl,
    input  lc3Pkg::word_t  mdr,
    output lc3Pkg::instr_u ir,
    output lc3Pkg::cc_t    cc,
    output lc3Pkg::word_t  bus
);

    lc3Pkg::word_t pc;
    lc3Pkg::word_t rd1;
    lc3Pkg::word_t rd2;
    lc3Pkg::word_t aluOut;
    lc3Pkg::word_t addrSum;

    regFile uRegs (
        .clk(clk), .rst_n(rst_n), .sr1(ctrl.sr1), .sr2(ctrl.sr2), .dr(ctrl.dr),
        .ldReg(ctrl.ldReg), .writeData(bus), .rd1(rd1), .rd2(rd2)
    );

    executeUnit uExec (
        .ir(ir), .ctrl(ctrl), .rd1(rd1), .rd2(rd2), .pc(pc),
        .aluOut(aluOut), .addrSum(addrSum)
    );

    ////////////////////
    // Bus source
    ////////////////////
    always_comb begin
        case (ctrl.busSel)
            lc3Pkg::busAlu:  bus = aluOut;
            lc3Pkg::busAddr: bus = addrSum;
            lc3Pkg::busMdr:  bus = mdr;
            default:         bus = pc;
        endcase
    end

    ////////////////////
    // PC and flags
    ////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc <= resetPc;
        end else if (ctrl.ldPc) begin
            case (ctrl.pcSel)
                lc3Pkg::pcInc:  pc <= pc + 1'b1;
                lc3Pkg::pcAddr: pc <= addrSum;  // Branch target
                default:        pc <= bus;      // JMP
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cc <= lc3Pkg::ccResetVal;
        end else if (ctrl.ldCc) begin
            cc <= {bus[15], bus == '0, !bus[15] && (bus != '0)};
        end
    end

    // Instruction word straight off the bus
    always_ff @(posedge clk) begin
        if (ctrl.ldIr) begin
            ir.raw <= bus;
        end
    end

endmodule

/* logic/memInterface.sv */
`timescale 1ns/10ps

module memInterface (
    input  logic            clk,
    input  logic            rst_n,
    input  lc3Pkg::word_t   bus,
    input  logic            ldMar,
    input  logic            ldMdr,
    input  lc3Pkg::memCmd_e memCmd,
    output lc3Pkg::word_t   mdr,
    output logic            memDone,
    output lc3Pkg::memReq_t memReq,
    output logic            reqValid,
    input  logic            reqReady,
    input  logic            rspValid,
    input  lc3Pkg::word_t   rspData
);

    typedef enum logic [1:0] {sIdle, sRequest, sAwait} state_e;

    state_e        state;
    lc3Pkg::word_t mar;
    logic          isWrite;
    logic          accepted;

    assign reqValid = (state == sRequest);
    assign accepted = reqValid && reqReady;
    assign memReq   = '{addr: mar, wdata: mdr, write: isWrite};

    ////////////////////
    // Handshake FSM
    ////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state   <= sIdle;
            isWrite <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= (accepted && isWrite) || (state == sAwait && rspValid);
            case (state)
                sIdle: if (memCmd != lc3Pkg::memNone) begin
                    state   <= sRequest;
                    isWrite <= (memCmd == lc3Pkg::memWrite);
                end
                sRequest: if (accepted) state <= isWrite ? sIdle : sAwait;
                sAwait: if (rspValid) state <= sIdle;   // One response per read
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ldMar) mar <= bus;
        if (ldMdr) begin
            mdr <= bus;
        end else if (state == sAwait && rspValid) begin
            mdr <= rspData;                             // Read data capture
        end
    end

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
    input  logic            clk,
    input  logic            rst_n,
    input  lc3Pkg::instr_u  ir,
    input  lc3Pkg::cc_t     cc,
    input  logic            memDone,
    output lc3Pkg::ctrl_t   ctrl,
    output lc3Pkg::memCmd_e memCmd,
    output logic            ldMar,
    output logic            ldMdr,
    output logic            halted
);

    typedef enum logic [3:0] {
        sFetchAddr, sFetchWait, sIrLoad, sExecute, sAddr,
        sReadWait, sWriteBack, sStoreData, sWriteWait, sHalt
    } state_e;

    state_e          state, nextState;
    lc3Pkg::opcode_e opcode;
    logic            isBaseRel;
    logic            isLoad;
    logic            takeBranch;

    assign opcode     = ir.operate.opcode;
    assign isBaseRel  = (opcode == lc3Pkg::opLdr) || (opcode == lc3Pkg::opStr);
    assign isLoad     = (opcode == lc3Pkg::opLd) || (opcode == lc3Pkg::opLdr);
    assign takeBranch = |(cc & {ir.branch.n, ir.branch.z, ir.branch.p});
    assign halted     = (state == sHalt);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= sFetchAddr;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////
    // Control word
    ////////////////////
    always_comb begin
        ctrl      = '0;
        memCmd    = lc3Pkg::memNone;
        ldMar     = 1'b0;
        ldMdr     = 1'b0;
        nextState = state;

        case (state)
            sFetchAddr: begin
                ctrl.busSel = lc3Pkg::busPc;            // MAR <- PC
                ldMar       = 1'b1;
                memCmd      = lc3Pkg::memRead;
                nextState   = sFetchWait;
            end

            sFetchWait: if (memDone) nextState = sIrLoad;

            sIrLoad: begin
                ctrl.busSel = lc3Pkg::busMdr;           // IR <- MDR
                ctrl.ldIr   = 1'b1;
                ctrl.ldPc   = 1'b1;                     // PC + 1
                nextState   = sExecute;
            end

            sExecute: begin
                nextState = sFetchAddr;
                case (opcode)
                    lc3Pkg::opAdd, lc3Pkg::opAnd, lc3Pkg::opNot: begin
                        ctrl.dr     = ir.operate.dr;
                        ctrl.sr1    = ir.operate.sr1;
                        ctrl.sr2    = ir.operate.imm5[2:0];
                        ctrl.useImm = ir.operate.immFlag;
                        ctrl.aluOp  = (opcode == lc3Pkg::opAdd) ? lc3Pkg::aluAdd :
                                      (opcode == lc3Pkg::opAnd) ? lc3Pkg::aluAnd :
                                                                  lc3Pkg::aluNot;
                        ctrl.busSel = lc3Pkg::busAlu;
                        ctrl.ldReg  = 1'b1;
                        ctrl.ldCc   = 1'b1;
                    end
                    lc3Pkg::opBr: begin
                        ctrl.addr2Sel = lc3Pkg::addr2Off9;
                        ctrl.pcSel    = lc3Pkg::pcAddr;
                        ctrl.ldPc     = takeBranch;     // Fall through when no flag matches
                    end
                    lc3Pkg::opLea: begin
                        ctrl.dr       = ir.pcRel.dr;
                        ctrl.addr2Sel = lc3Pkg::addr2Off9;
                        ctrl.busSel   = lc3Pkg::busAddr;
                        ctrl.ldReg    = 1'b1;
                        ctrl.ldCc     = 1'b1;
                    end
                    lc3Pkg::opJmp: begin
                        ctrl.sr1    = ir.baseRel.baseR; // R7 for RET
                        ctrl.aluOp  = lc3Pkg::aluPassA;
                        ctrl.busSel = lc3Pkg::busAlu;
                        ctrl.pcSel  = lc3Pkg::pcBus;
                        ctrl.ldPc   = 1'b1;
                    end
                    lc3Pkg::opLd, lc3Pkg::opLdr, lc3Pkg::opSt, lc3Pkg::opStr: begin
                        nextState = sAddr;
                    end
                    default: nextState = sHalt;         // JSR, TRAP, LDI, STI, RTI, reserved
                endcase
            end

            sAddr: begin
                ctrl.sr1       = ir.baseRel.baseR;
                ctrl.addr1Base = isBaseRel;
                ctrl.addr2Sel  = isBaseRel ? lc3Pkg::addr2Off6 : lc3Pkg::addr2Off9;
                ctrl.busSel    = lc3Pkg::busAddr;
                ldMar          = 1'b1;
                if (isLoad) begin
                    memCmd    = lc3Pkg::memRead;
                    nextState = sReadWait;
                end else begin
                    nextState = sStoreData;
                end
            end

            sReadWait: if (memDone) nextState = sWriteBack;

            sWriteBack: begin
                ctrl.dr     = ir.pcRel.dr;
                ctrl.busSel = lc3Pkg::busMdr;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
                nextState   = sFetchAddr;
            end

            sStoreData: begin
                ctrl.sr1    = ir.pcRel.dr;              // Store source register
                ctrl.aluOp  = lc3Pkg::aluPassA;
                ctrl.busSel = lc3Pkg::busAlu;
                ldMdr       = 1'b1;
                memCmd      = lc3Pkg::memWrite;
                nextState   = sWriteWait;
            end

            sWriteWait: if (memDone) nextState = sFetchAddr;

            default: nextState = sHalt;                 // Stay here until reset
        endcase
    end

endmodule

/* logic/lc3Core.sv */
`timescale 1ns/10ps

module lc3Core #(
    parameter lc3Pkg::word_t resetPc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output lc3Pkg::memReq_t memReq,
    output logic            reqValid,
    input  logic            reqReady,
    input  logic            rspValid,
    input  lc3Pkg::word_t   rspData,
    output logic            halted
);

    lc3Pkg::ctrl_t   ctrl;
    lc3Pkg::instr_u  ir;
    lc3Pkg::cc_t     cc;
    lc3Pkg::word_t   bus;
    lc3Pkg::word_t   mdr;
    lc3Pkg::memCmd_e memCmd;
    logic            ldMar;
    logic            ldMdr;
    logic            memDone;

    controlUnit uCtrl (
        .clk(clk), .rst_n(rst_n), .ir(ir), .cc(cc), .memDone(memDone),
        .ctrl(ctrl), .memCmd(memCmd), .ldMar(ldMar), .ldMdr(ldMdr), .halted(halted)
    );

    dataPath #(.resetPc(resetPc)) uDp (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .mdr(mdr), .ir(ir), .cc(cc), .bus(bus)
    );

    memInterface uMem (
        .clk(clk), .rst_n(rst_n), .bus(bus), .ldMar(ldMar), .ldMdr(ldMdr),
        .memCmd(memCmd), .mdr(mdr), .memDone(memDone), .memReq(memReq),
        .reqValid(reqValid), .reqReady(reqReady), .rspValid(rspValid), .rspData(rspData)
    );

endmodule

/* sim/memModel.sv */
`timescale 1ns/10ps

module memModel (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stallEn,
    input  logic            loadEn,
    input  lc3Pkg::word_t   loadAddr,
    input  lc3Pkg::word_t   loadData,
    input  lc3Pkg::memReq_t memReq,
    input  logic            reqValid,
    output logic            reqReady,
    output logic            rspValid,
    output lc3Pkg::word_t   rspData
);

    localparam int logDepth = 64;

    lc3Pkg::word_t cells [256];                 // Low address byte only
    lc3Pkg::word_t logAddr [logDepth];
    lc3Pkg::word_t logData [logDepth];
    int            logCount;
    logic          pending;
    lc3Pkg::word_t pendAddr;
    int            delay;

    initial begin
        void'($urandom(64));                    // Fixed seed for stalls and latency
        reqReady = 1'b0;
        rspValid = 1'b0;
        rspData  = '0;
        logCount = 0;
        pending  = 1'b0;
        pendAddr = '0;
        delay    = 0;
        forever begin
            @(negedge clk);                     // Handshake signals are stable here
            if (loadEn) cells[loadAddr[7:0]] = loadData;
            if (!rst_n) begin
                logCount = 0;
                pending  = 1'b0;
            end else if (reqValid && reqReady) begin
                if (memReq.write) begin
                    cells[memReq.addr[7:0]] = memReq.wdata;
                    if (logCount < logDepth) begin
                        logAddr[logCount] = memReq.addr;
                        logData[logCount] = memReq.wdata;
                    end
                    logCount++;
                end else begin
                    pending  = 1'b1;
                    pendAddr = memReq.addr;
                    delay    = stallEn ? int'($urandom_range(4)) : 0;
                end
            end
            @(posedge clk);
            #1;
            rspValid = 1'b0;
            if (pending && delay == 0) begin
                rspValid = 1'b1;                // Earliest one cycle after acceptance
                rspData  = cells[pendAddr[7:0]];
                pending  = 1'b0;
            end else if (pending) begin
                delay--;
            end
            reqReady = rst_n && (!stallEn || $urandom_range(3) != 0);
        end
    end

endmodule

/* sim/tbLc3.sv */
`timescale 1ns/10ps

module tbLc3;

    localparam int            numRuns      = 9;
    localparam int            cyclesPerRun = 3000;
    localparam int            cycleLimit   = numRuns * cyclesPerRun;
    localparam int            imageSize    = 64;
    localparam lc3Pkg::word_t haltWord     = 16'hD000;     // Reserved opcode

    logic            clk;
    logic            rst_n;
    logic            stallEn;
    logic            loadEn;
    lc3Pkg::word_t   loadAddr;
    lc3Pkg::word_t   loadData;
    lc3Pkg::memReq_t memReq;
    logic            reqValid;
    logic            reqReady;
    logic            rspValid;
    lc3Pkg::word_t   rspData;
    logic            halted;

    lc3Pkg::word_t image [imageSize];
    int            loadPtr;
    lc3Pkg::word_t refAddr [4][64];                         // Unstalled write logs
    lc3Pkg::word_t refData [4][64];
    int            refCount [4];
    int            checkCount;
    int            errorCount;
    int            cycleCount = 0;

    lc3Core #(.resetPc(16'h0000)) uut (
        .clk(clk), .rst_n(rst_n), .memReq(memReq), .reqValid(reqValid), .reqReady(reqReady),
        .rspValid(rspValid), .rspData(rspData), .halted(halted)
    );

    memModel memory (
        .clk(clk), .rst_n(rst_n), .stallEn(stallEn), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .memReq(memReq), .reqValid(reqValid), .reqReady(reqReady),
        .rspValid(rspValid), .rspData(rspData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Instruction encoding
    ////////////////////
    function automatic lc3Pkg::word_t operateWord(input lc3Pkg::opcode_e op, input int dr,
                                                  input int sr1, input logic imm, input int low5);
        return {op, dr[2:0], sr1[2:0], imm, low5[4:0]};
    endfunction

    function automatic lc3Pkg::word_t pcRelWord(input lc3Pkg::opcode_e op, input int r,
                                                input int off);
        return {op, r[2:0], off[8:0]};
    endfunction

    function automatic lc3Pkg::word_t baseRelWord(input lc3Pkg::opcode_e op, input int r,
                                                  input int base, input int off);
        return {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic lc3Pkg::word_t branchWord(input logic [2:0] nzp, input int off);
        return {lc3Pkg::opBr, nzp, off[8:0]};
    endfunction

    function automatic int offsetTo(input int target);
        return target - (loadPtr + 1);                      // Relative to the next PC
    endfunction

    function automatic lc3Pkg::word_t effectiveAddr(input int at, input int off);
        return lc3Pkg::word_t'(at + 1 + off);
    endfunction

    ////////////////////
    // Program loading and running
    ////////////////////
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clearImage();
        for (int a = 0; a < imageSize; a++) begin
            image[a] = {8'hD0, 8'(a)};                      // Stray fetches halt
        end
        loadPtr = 0;
    endtask

    task automatic put(input lc3Pkg::word_t w);
        image[loadPtr] = w;
        loadPtr++;
    endtask

    task automatic runProgram(input logic stall);
        stallEn = stall;
        for (int a = 0; a < imageSize; a++) begin
            loadEn   = 1'b1;
            loadAddr = lc3Pkg::word_t'(a);
            loadData = image[a];
            nextCycle();
        end
        loadEn = 1'b0;
        rst_n  = 1'b0;
        repeat (10) nextCycle();
        rst_n = 1'b1;
        while (!halted) nextCycle();                        // Global counter bounds this
    endtask

    ////////////////////
    // Checks
    ////////////////////
    task automatic checkWord(input string name, input lc3Pkg::word_t expected,
                             input lc3Pkg::word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic expectWrite(input string name, input int idx, input lc3Pkg::word_t addr,
                               input lc3Pkg::word_t data);
        if (memory.logCount <= idx) begin
            checkCount++;
            errorCount++;
            $display("%s: store number %0d never reached memory", name, idx);
        end else begin
            checkWord({name, " address"}, addr, memory.logAddr[idx]);
            checkWord({name, " data"}, data, memory.logData[idx]);
        end
    endtask

    task automatic checkLogLength(input string name, input int n);
        checkWord({name, " write count"}, lc3Pkg::word_t'(n), lc3Pkg::word_t'(memory.logCount));
    endtask

    task automatic compareWithUnstalled(input int id, input string name, input logic stall);
        if (!stall) begin
            refCount[id] = memory.logCount;
            for (int i = 0; i < 64; i++) begin
                refAddr[id][i] = memory.logAddr[i];
                refData[id][i] = memory.logData[i];
            end
        end else begin
            checkLogLength({name, " vs unstalled"}, refCount[id]);
            for (int i = 0; i < refCount[id] && i < memory.logCount; i++) begin
                checkWord({name, " vs unstalled address"}, refAddr[id][i], memory.logAddr[i]);
                checkWord({name, " vs unstalled data"}, refData[id][i], memory.logData[i]);
            end
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic testArithmetic(input logic stall);
        string         name;
        lc3Pkg::word_t a;
        lc3Pkg::word_t b;
        name = stall ? "arithmetic stalled" : "arithmetic";
        a    = 16'h1234;
        b    = 16'hF0F5;
        clearImage();
        image[16'h30] = a;
        image[16'h31] = b;
        put(pcRelWord(lc3Pkg::opLd, 1, offsetTo(16'h30)));
        put(pcRelWord(lc3Pkg::opLd, 2, offsetTo(16'h31)));
        put(operateWord(lc3Pkg::opAdd, 3, 1, 1'b0, 2));
        put(pcRelWord(lc3Pkg::opSt, 3, offsetTo(16'h40)));
        put(operateWord(lc3Pkg::opAdd, 4, 1, 1'b1, -7));
        put(pcRelWord(lc3Pkg::opSt, 4, offsetTo(16'h41)));
        put(operateWord(lc3Pkg::opAnd, 5, 1, 1'b0, 2));
        put(pcRelWord(lc3Pkg::opSt, 5, offsetTo(16'h42)));
        put(operateWord(lc3Pkg::opAnd, 6, 2, 1'b1, 15));
        put(pcRelWord(lc3Pkg::opSt, 6, offsetTo(16'h43)));
        put(operateWord(lc3Pkg::opNot, 7, 2, 1'b1, 31));   // NOT keeps low bits all ones
        put(pcRelWord(lc3Pkg::opSt, 7, offsetTo(16'h44)));
        put(haltWord);
        runProgram(stall);
        expectWrite(name, 0, 16'h40, lc3Pkg::word_t'(a + b));
        expectWrite(name, 1, 16'h41, lc3Pkg::word_t'(a + 16'hFFF9));
        expectWrite(name, 2, 16'h42, a & b);
        expectWrite(name, 3, 16'h43, b & 16'h000F);
        expectWrite(name, 4, 16'h44, ~b);
        checkLogLength(name, 5);
        checkWord({name, " memory"}, lc3Pkg::word_t'(a + b), memory.cells[8'h40]);
        compareWithUnstalled(0, name, stall);
    endtask

    task automatic testBranching(input logic stall);
        string name;
        name = stall ? "branching stalled" : "branching";
        clearImage();
        image[16'h30] = 16'd5;                              // Loop start value
        put(pcRelWord(lc3Pkg::opLd, 1, offsetTo(16'h30)));
        put(operateWord(lc3Pkg::opAnd, 2, 2, 1'b1, 0));
        put(operateWord(lc3Pkg::opAdd, 2, 2, 1'b1, 1));    // Loop body at 2
        put(operateWord(lc3Pkg::opAdd, 1, 1, 1'b1, -1));
        put(branchWord(3'b001, offsetTo(2)));
        put(branchWord(3'b010, offsetTo(8)));
        put(pcRelWord(lc3Pkg::opSt, 1, offsetTo(16'h41)));
        put(pcRelWord(lc3Pkg::opSt, 2, offsetTo(16'h42)));
        put(pcRelWord(lc3Pkg::opSt, 2, offsetTo(16'h40)));
        put(branchWord(3'b100, offsetTo(11)));              // Not taken, cc is z
        put(haltWord);
        put(pcRelWord(lc3Pkg::opSt, 1, offsetTo(16'h43)));
        put(haltWord);
        runProgram(stall);
        expectWrite(name, 0, 16'h40, 16'd5);
        checkLogLength(name, 1);
        compareWithUnstalled(1, name, stall);
    endtask

    task automatic testLoads(input logic stall);
        string name;
        name = stall ? "loads stalled" : "loads";
        clearImage();
        image[16'h30] = 16'hBEEF;
        image[16'h38] = 16'h5A5A;
        put(pcRelWord(lc3Pkg::opLd, 1, offsetTo(16'h30)));
        put(pcRelWord(lc3Pkg::opSt, 1, offsetTo(16'h40)));
        put(pcRelWord(lc3Pkg::opLea, 2, 16'h35));           // At address 2
        put(pcRelWord(lc3Pkg::opSt, 2, offsetTo(16'h41)));
        put(pcRelWord(lc3Pkg::opLea, 3, 16'h36));           // At address 4
        put(baseRelWord(lc3Pkg::opLdr, 4, 3, -3));
        put(pcRelWord(lc3Pkg::opSt, 4, offsetTo(16'h42)));
        put(pcRelWord(lc3Pkg::opLea, 5, -6));               // At address 7
        put(pcRelWord(lc3Pkg::opSt, 5, offsetTo(16'h43)));
        put(haltWord);
        runProgram(stall);
        expectWrite(name, 0, 16'h40, image[16'h30]);
        expectWrite(name, 1, 16'h41, effectiveAddr(2, 16'h35));
        expectWrite(name, 2, 16'h42, image[effectiveAddr(4, 16'h36) - 3]);
        expectWrite(name, 3, 16'h43, effectiveAddr(7, -6));
        checkLogLength(name, 4);
        compareWithUnstalled(2, name, stall);
    endtask

    task automatic testStoresJumps(input logic stall);
        string name;
        name = stall ? "stores and jumps stalled" : "stores and jumps";
        clearImage();
        image[16'h30] = 16'h1111;
        put(pcRelWord(lc3Pkg::opLd, 1, offsetTo(16'h30)));
        put(pcRelWord(lc3Pkg::opLea, 2, offsetTo(16'h48)));
        put(baseRelWord(lc3Pkg::opStr, 1, 2, 2));
        put(baseRelWord(lc3Pkg::opStr, 2, 2, -4));
        put(pcRelWord(lc3Pkg::opLea, 7, offsetTo(7)));
        put(baseRelWord(lc3Pkg::opJmp, 0, 7, 0));          // RET
        put(pcRelWord(lc3Pkg::opSt, 1, offsetTo(16'h4F)));
        put(pcRelWord(lc3Pkg::opSt, 7, offsetTo(16'h40)));
        put(haltWord);
        runProgram(stall);
        expectWrite(name, 0, 16'h48 + 2, image[16'h30]);
        expectWrite(name, 1, 16'h48 - 4, 16'h48);
        expectWrite(name, 2, 16'h40, 16'd7);
        checkLogLength(name, 3);
        compareWithUnstalled(3, name, stall);
    endtask

    task automatic testHalting();
        logic sawRequest;
        clearImage();
        put(operateWord(lc3Pkg::opAdd, 1, 1, 1'b1, 1));
        put(16'h4800);                                      // JSR is not supported
        put(pcRelWord(lc3Pkg::opSt, 1, offsetTo(16'h40)));
        put(haltWord);
        runProgram(1'b0);
        sawRequest = 1'b0;
        repeat (50) begin
            nextCycle();
            if (reqValid) sawRequest = 1'b1;
        end
        checkBit("halting request after halt", 1'b0, sawRequest);
        checkBit("halting still halted", 1'b1, halted);
        checkLogLength("halting", 0);
    endtask

    initial begin
        rst_n      = 1'b0;
        stallEn    = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        checkCount = 0;
        errorCount = 0;
        nextCycle();                                        // Align stimulus with the clock
        testArithmetic(1'b0);
        testBranching(1'b0);
        testLoads(1'b0);
        testStoresJumps(1'b0);
        testArithmetic(1'b1);                               // Same programs with back-pressure
        testBranching(1'b1);
        testLoads(1'b1);
        testStoresJumps(1'b1);
        testHalting();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/lc3Pkg.sv
logic/regFile.sv
logic/executeUnit.sv
logic/dataPath.sv
logic/memInterface.sv
logic/controlUnit.sv
logic/lc3Core.sv
sim/memModel.sv
sim/tbLc3.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tbLc3
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
